// File: compile.f
source/pcie_cfg_pkg.sv
source/pcie_cfg_poll.sv
source/pcie_read_split.sv
source/pcie_cfg_top.sv
sim/pcie_cfg_assert.sv
sim/tb_pcie_cfg.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_pcie_cfg
FILELIST := compile.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass message appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_pcie_cfg.sv
// testbench for the PCIe configuration shim.
// models the configuration management port, drives read requests and
// checks the polled settings and the split TLP stream against a reference.

module tb_pcie_cfg;

    import pcie_cfg_pkg::*;

    localparam int PF_COUNT   = 2;
    localparam int VF_COUNT   = 2;
    localparam int F_COUNT    = PF_COUNT + VF_COUNT;
    localparam int VF_OFFSET  = 64;
    localparam int CAP_OFFSET = 'h0C0;
    localparam int WAIT_LIMIT = 2000;
    localparam cfg_addr_t DEV_CTRL_ADDR = cfg_addr_t'((CAP_OFFSET + 8) / 4);

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    cfg_addr_t                cfg_addr;
    func_num_t                cfg_func;
    logic                     cfg_read;
    logic [31:0]              cfg_rdata = '0;
    logic                     cfg_done = 1'b0;
    size_code_t [F_COUNT-1:0] max_payload;
    logic                     req_valid = 1'b0;
    logic                     req_ready;
    rd_req_t                  req = '0;
    logic                     tlp_valid;
    logic                     tlp_ready = 1'b1;
    rd_tlp_t                  tlp;

    logic [31:0] lfsr = 32'h4f57;
    logic [31:0] dev_ctrl [256];
    rd_tlp_t     exp_q [$];
    tag_t        ref_tag = '0;
    tag_t        last_tag = '0;
    logic        wrap_basic = 1'b0;
    logic        wrap_ext = 1'b0;
    logic        bp_en = 1'b0;
    logic        busy = 1'b0;
    int          wait_cnt = 0;
    int          reads_done = 0;
    int          errors = 0;
    int          checks = 0;

    pcie_cfg_top #(
        .PF_COUNT       (PF_COUNT),
        .VF_COUNT       (VF_COUNT),
        .VF_OFFSET      (VF_OFFSET),
        .PCIE_CAP_OFFSET(CAP_OFFSET),
        .POLL_DELAY     (15)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .cfg_addr   (cfg_addr),
        .cfg_func   (cfg_func),
        .cfg_read   (cfg_read),
        .cfg_rdata  (cfg_rdata),
        .cfg_done   (cfg_done),
        .max_payload(max_payload),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .tlp_valid  (tlp_valid),
        .tlp_ready  (tlp_ready),
        .tlp        (tlp)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // helpers
    // ======================================================================

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic func_num_t map_func(input int f);
        if (f < PF_COUNT) return func_num_t'(f);
        return func_num_t'(VF_OFFSET + f - PF_COUNT);
    endfunction

    function automatic logic is_mapped(input func_num_t n);
        for (int f = 0; f < F_COUNT; f++) begin
            if (map_func(f) == n) return 1'b1;
        end
        return 1'b0;
    endfunction

    // size codes kept to the defined range 128 to 4096 bytes.
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = rand_bits(32);
        w[DEV_CTRL_MRRS_LSB +: 3] = size_code_t'(rand_bits(3) % 6);
        w[DEV_CTRL_MPS_LSB +: 3] = size_code_t'(rand_bits(3) % 6);
        return w;
    endfunction

    // reference split of one request into the expected TLP list.
    function automatic void expect_tlps(input rd_req_t r);
        logic [31:0] word;
        logic        ext;
        int          limit;
        int          left;
        rd_tlp_t     t;
        word = dev_ctrl[map_func(int'(r.func))];
        ext = word[DEV_CTRL_EXT_TAG];
        limit = 128 << word[DEV_CTRL_MRRS_LSB +: 3];
        left = int'(r.len);
        t.func = r.func;
        t.addr = r.addr;
        while (left > 0) begin
            t.len = byte_len_t'((left < limit) ? left : limit);
            if (ext) begin
                // 256 tags.
                t.tag = ref_tag;
                ref_tag = tag_t'((int'(ref_tag) + 1) % 256);
            end else begin
                // 32 tags, counting on from the low bits.
                t.tag = tag_t'(int'(ref_tag) % 32);
                ref_tag = tag_t'((int'(t.tag) + 1) % 32);
            end
            exp_q.push_back(t);
            t.addr = t.addr + dma_addr_t'(t.len);
            left = left - int'(t.len);
        end
    endfunction

    task automatic check_tlp(input rd_tlp_t got, input rd_tlp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: TLP f%0d a%h l%0d t%0d, expected f%0d a%h l%0d t%0d",
                $time, got.func, got.addr, got.len, got.tag,
                exp.func, exp.addr, exp.len, exp.tag);
        end
    endtask

    task automatic check_size(input size_code_t got, input size_code_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout at %0t while waiting for %s", $time, why);
        $display("TEST FAILED");
        $finish;
    endtask

    // all settings cleared, no TLP and ready for a request.
    task automatic check_reset_state();
        for (int f = 0; f < F_COUNT; f++) begin
            check_bit(dut_i.ext_tag_en[f], 1'b0, "ext_tag_en");
            check_size(dut_i.max_read_req[f], '0, "max_read_req");
            check_size(max_payload[f], '0, "max_payload");
        end
        check_bit(tlp_valid, 1'b0, "tlp_valid");
        check_bit(req_ready, 1'b1, "req_ready");
    endtask

    task automatic check_settings();
        func_num_t n;
        for (int f = 0; f < F_COUNT; f++) begin
            n = map_func(f);
            check_bit(dut_i.ext_tag_en[f], dev_ctrl[n][DEV_CTRL_EXT_TAG], "ext_tag_en");
            check_size(dut_i.max_read_req[f], dev_ctrl[n][DEV_CTRL_MRRS_LSB +: 3],
                "max_read_req");
            check_size(max_payload[f], dev_ctrl[n][DEV_CTRL_MPS_LSB +: 3], "max_payload");
        end
    endtask

    // n full polling passes and one more cycle for the capture.
    task automatic wait_passes(input int n);
        int target;
        int t;
        target = reads_done + n * F_COUNT;
        t = 0;
        while (reads_done < target) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) abort_run("polling passes");
        end
        @(negedge clk);
    endtask

    task automatic run_req(input rd_req_t r);
        int t;
        expect_tlps(r);
        req = r;
        req_valid = 1'b1;
        t = 0;
        while (!req_ready) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) abort_run("req_ready");
        end
        @(negedge clk);
        req_valid = 1'b0;
        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) abort_run("the TLPs of a request");
        end
    endtask

    task automatic random_reqs(input int count);
        rd_req_t r;
        for (int i = 0; i < count; i++) begin
            r.func = func_num_t'(rand_bits(2));
            r.addr = {rand_bits(32), rand_bits(32)};
            r.len = byte_len_t'(rand_bits(12) + 1);
            run_req(r);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("%-32s %s", name, (errors == err0) ? "pass" : "fail");
    endtask

    // ======================================================================
    // config space model and TLP sink
    // ======================================================================

    always @(negedge clk) begin
        if (cfg_done) begin
            cfg_done = 1'b0;
            busy = 1'b0;
        end else if (cfg_read && !busy) begin
            busy = 1'b1;
            wait_cnt = int'(rand_bits(2));
            if (!is_mapped(cfg_func)) begin
                errors++;
                $display("config read of unmapped function %0d", cfg_func);
            end
            if (cfg_addr !== DEV_CTRL_ADDR) begin
                errors++;
                $display("config read of address %h instead of Device Control", cfg_addr);
            end
        end else if (busy) begin
            if (wait_cnt == 0) begin
                cfg_rdata = dev_ctrl[cfg_func];
                cfg_done = 1'b1;
                reads_done++;
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(negedge clk) begin
        tlp_ready = bp_en ? (rand_bits(2) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && tlp_valid && tlp_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected TLP with tag %0d at %0t", tlp.tag, $time);
            end else begin
                check_tlp(tlp, exp_q.pop_front());
            end
            if (tlp.tag == 8'd0 && last_tag == 8'd31) wrap_basic = 1'b1;
            if (tlp.tag == 8'd0 && last_tag == 8'd255) wrap_ext = 1'b1;
            last_tag = tlp.tag;
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        logic [31:0] w;
        rd_req_t     r;
        int          err0;
        // every word follows its function number until loaded.
        for (int i = 0; i < 256; i++) begin
            dev_ctrl[i] = {4{i[7:0]}};
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        err0 = errors;
        @(negedge clk);
        check_reset_state();
        report_test("reset values", err0);

        err0 = errors;
        for (int f = 0; f < F_COUNT; f++) begin
            dev_ctrl[map_func(f)] = random_word();
        end
        wait_passes(2);
        check_settings();
        report_test("polled settings", err0);

        // first VF gets every field changed.
        err0 = errors;
        w = dev_ctrl[VF_OFFSET];
        w[DEV_CTRL_EXT_TAG] = ~w[DEV_CTRL_EXT_TAG];
        w[DEV_CTRL_MRRS_LSB +: 3] = size_code_t'((int'(w[DEV_CTRL_MRRS_LSB +: 3]) + 1) % 6);
        w[DEV_CTRL_MPS_LSB +: 3] = size_code_t'((int'(w[DEV_CTRL_MPS_LSB +: 3]) + 2) % 6);
        dev_ctrl[VF_OFFSET] = w;
        wait_passes(2);
        check_settings();
        report_test("register change", err0);

        err0 = errors;
        random_reqs(40);
        report_test("random requests", err0);

        // 128 byte chunks with basic tags on PF0 and extended tags on PF1.
        err0 = errors;
        dev_ctrl[0][DEV_CTRL_EXT_TAG] = 1'b0;
        dev_ctrl[0][DEV_CTRL_MRRS_LSB +: 3] = 3'd0;
        dev_ctrl[1][DEV_CTRL_EXT_TAG] = 1'b1;
        dev_ctrl[1][DEV_CTRL_MRRS_LSB +: 3] = 3'd0;
        wait_passes(2);
        check_settings();
        wrap_basic = 1'b0;
        wrap_ext = 1'b0;
        r.len = 13'd4096;
        for (int i = 0; i < 11; i++) begin
            r.func = (i < 2) ? 8'd0 : 8'd1;
            r.addr = {rand_bits(32), rand_bits(32)};
            run_req(r);
        end
        check_bit(wrap_basic, 1'b1, "tag wrap after 31");
        check_bit(wrap_ext, 1'b1, "tag wrap after 255");
        report_test("tag wrap", err0);

        err0 = errors;
        bp_en = 1'b1;
        random_reqs(40);
        bp_en = 1'b0;
        report_test("back-pressure", err0);

        errors += dut_i.assert_i.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/pcie_cfg_assert.sv
// handshake assertions for the PCIe configuration shim.
// bound to the top level.

module pcie_cfg_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    cfg_read,
    input logic                    cfg_done,
    input pcie_cfg_pkg::func_num_t cfg_func,
    input logic                    tlp_valid,
    input logic                    tlp_ready,
    input pcie_cfg_pkg::rd_tlp_t   tlp
);

    int fail_count = 0;

    // TLP holds under back-pressure.
    tlp_hold: assert property (@(posedge clk) disable iff (rst)
        tlp_valid && !tlp_ready |=> tlp_valid && $stable(tlp))
        else begin
            fail_count++;
            $error("tlp changed while valid and not ready");
        end

    // read strobe held until done, dropped right after.
    read_hold: assert property (@(posedge clk) disable iff (rst)
        cfg_read && !cfg_done |=> cfg_read)
        else begin
            fail_count++;
            $error("cfg_read dropped before cfg_done");
        end

    read_end: assert property (@(posedge clk) disable iff (rst)
        cfg_read && cfg_done |=> !cfg_read)
        else begin
            fail_count++;
            $error("cfg_read still high after cfg_done");
        end

    func_hold: assert property (@(posedge clk) disable iff (rst)
        cfg_read && !cfg_done |=> $stable(cfg_func))
        else begin
            fail_count++;
            $error("cfg_func changed during a read");
        end

endmodule

bind pcie_cfg_top pcie_cfg_assert assert_i (
    .clk      (clk),
    .rst      (rst),
    .cfg_read (cfg_read),
    .cfg_done (cfg_done),
    .cfg_func (cfg_func),
    .tlp_valid(tlp_valid),
    .tlp_ready(tlp_ready),
    .tlp      (tlp)
);

// File: source/pcie_cfg_top.sv
// PCIe configuration shim top level.
// Device Control poller feeding the read request splitter, with maximum
// payload size exported for the write path.

module pcie_cfg_top #(
    parameter int PF_COUNT        = 2,
    parameter int VF_COUNT        = 2,
    parameter int VF_OFFSET       = 64,
    parameter int PCIE_CAP_OFFSET = 'h0C0,
    parameter int POLL_DELAY      = 255,
    localparam int F_COUNT        = PF_COUNT + VF_COUNT
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // configuration management port
    output pcie_cfg_pkg::cfg_addr_t               cfg_addr,
    output pcie_cfg_pkg::func_num_t               cfg_func,
    output logic                                  cfg_read,
    input  logic [31:0]                           cfg_rdata,
    input  logic                                  cfg_done,

    // payload limit per function
    output pcie_cfg_pkg::size_code_t [F_COUNT-1:0] max_payload,

    // read requests
    input  logic                                  req_valid,
    output logic                                  req_ready,
    input  pcie_cfg_pkg::rd_req_t                 req,

    // read TLPs
    output logic                                  tlp_valid,
    input  logic                                  tlp_ready,
    output pcie_cfg_pkg::rd_tlp_t                 tlp
);

    import pcie_cfg_pkg::*;

    // settings from poller to splitter.
    logic [F_COUNT-1:0]        ext_tag_en;
    size_code_t [F_COUNT-1:0]  max_read_req;

    pcie_cfg_poll #(
        .PF_COUNT       (PF_COUNT),
        .VF_COUNT       (VF_COUNT),
        .VF_OFFSET      (VF_OFFSET),
        .PCIE_CAP_OFFSET(PCIE_CAP_OFFSET),
        .POLL_DELAY     (POLL_DELAY)
    ) poll_i (
        .clk         (clk),
        .rst         (rst),
        .cfg_addr    (cfg_addr),
        .cfg_func    (cfg_func),
        .cfg_read    (cfg_read),
        .cfg_rdata   (cfg_rdata),
        .cfg_done    (cfg_done),
        .ext_tag_en  (ext_tag_en),
        .max_read_req(max_read_req),
        .max_payload (max_payload)
    );

    pcie_read_split #(
        .F_COUNT(F_COUNT)
    ) split_i (
        .clk         (clk),
        .rst         (rst),
        .ext_tag_en  (ext_tag_en),
        .max_read_req(max_read_req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .tlp_valid   (tlp_valid),
        .tlp_ready   (tlp_ready),
        .tlp         (tlp)
    );

endmodule

// File: source/pcie_read_split.sv
// PCIe read request splitter.
// cuts DMA read requests into tagged read TLP requests no larger than the
// function's maximum read request size.

module pcie_read_split #(
    parameter int F_COUNT = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // per-function settings
    input  logic [F_COUNT-1:0]                    ext_tag_en,
    input  pcie_cfg_pkg::size_code_t [F_COUNT-1:0] max_read_req,

    // request input
    input  logic                                  req_valid,
    output logic                                  req_ready,
    input  pcie_cfg_pkg::rd_req_t                 req,

    // TLP output
    output logic                                  tlp_valid,
    input  logic                                  tlp_ready,
    output pcie_cfg_pkg::rd_tlp_t                 tlp
);

    import pcie_cfg_pkg::*;

    localparam int IDX_W = (F_COUNT > 1) ? $clog2(F_COUNT) : 1;

    // bytes left after the TLP on the output.
    byte_len_t rem_len;
    tag_t      tag_cnt;

    // next chunk source, either a new request or the running one.
    func_num_t src_func;
    dma_addr_t src_addr;
    byte_len_t src_len;

    logic       src_ext;
    size_code_t src_mrrs;
    byte_len_t  limit;
    byte_len_t  chunk_len;
    tag_t       tag_cur;
    tag_t       tag_next;

    logic req_take;
    logic tlp_take;
    logic load_chunk;

    assign req_ready  = !tlp_valid;
    assign req_take   = req_valid && req_ready;
    assign tlp_take   = tlp_valid && tlp_ready;
    assign load_chunk = req_take || (tlp_take && rem_len != '0);

    // ======================================================================
    // chunk formation
    // ======================================================================

    always_comb begin
        if (tlp_valid) begin
            src_func = tlp.func;
            src_addr = tlp.addr + dma_addr_t'(tlp.len);
            src_len  = rem_len;
        end else begin
            src_func = req.func;
            src_addr = req.addr;
            src_len  = req.len;
        end

        // settings sampled now, unknown functions get the smallest limits.
        if (int'(src_func) < F_COUNT) begin
            src_ext  = ext_tag_en[src_func[IDX_W-1:0]];
            src_mrrs = max_read_req[src_func[IDX_W-1:0]];
        end else begin
            src_ext  = 1'b0;
            src_mrrs = '0;
        end

        limit     = size_bytes(src_mrrs);
        chunk_len = (src_len < limit) ? src_len : limit;

        // 5-bit tag space when extended tags are off.
        if (src_ext) begin
            tag_cur  = tag_cnt;
            tag_next = tag_cnt + 1'b1;
        end else begin
            tag_cur  = {3'b000, tag_cnt[4:0]};
            tag_next = (int'(tag_cur) == TAG_LAST_BASIC) ? '0 : tag_cur + 1'b1;
        end
    end

    // ======================================================================
    // control
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            tlp_valid <= 1'b0;
            tag_cnt   <= '0;
        end else begin
            if (load_chunk) begin
                tlp_valid <= 1'b1;
                tag_cnt   <= tag_next;
            end else if (tlp_take) begin
                // last chunk gone.
                tlp_valid <= 1'b0;
            end
        end
    end

    // output TLP and remaining length.
    always_ff @(posedge clk) begin
        if (load_chunk) begin
            tlp.func <= src_func;
            tlp.addr <= src_addr;
            tlp.len  <= chunk_len;
            tlp.tag  <= tag_cur;
            rem_len  <= src_len - chunk_len;
        end
    end

endmodule

// File: source/pcie_cfg_poll.sv
// PCIe Device Control poller.
// reads Device Control of every PF and VF in turn over the configuration
// management port and keeps the tag, read request and payload settings.

module pcie_cfg_poll #(
    parameter int PF_COUNT        = 2,
    parameter int VF_COUNT        = 2,
    parameter int VF_OFFSET       = 64,
    parameter int PCIE_CAP_OFFSET = 'h0C0,
    parameter int POLL_DELAY      = 255,
    localparam int F_COUNT        = PF_COUNT + VF_COUNT
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // configuration management port
    output pcie_cfg_pkg::cfg_addr_t               cfg_addr,
    output pcie_cfg_pkg::func_num_t               cfg_func,
    output logic                                  cfg_read,
    input  logic [31:0]                           cfg_rdata,
    input  logic                                  cfg_done,

    // per-function settings
    output logic [F_COUNT-1:0]                    ext_tag_en,
    output pcie_cfg_pkg::size_code_t [F_COUNT-1:0] max_read_req,
    output pcie_cfg_pkg::size_code_t [F_COUNT-1:0] max_payload
);

    import pcie_cfg_pkg::*;

    localparam int IDX_W = (F_COUNT > 1) ? $clog2(F_COUNT) : 1;
    localparam int DLY_W = (POLL_DELAY > 0) ? $clog2(POLL_DELAY + 1) : 1;
    localparam int SZ_W  = $bits(size_code_t);

    // dword address of Device Control.
    localparam cfg_addr_t DEV_CTRL_ADDR =
        cfg_addr_t'((PCIE_CAP_OFFSET + DEV_CTRL_OFFSET) >> 2);

    typedef enum logic {
        ST_WAIT,
        ST_READ
    } state_t;

    state_t           state;
    logic [DLY_W-1:0] delay_cnt;
    logic [IDX_W-1:0] func_idx;
    logic             func_last;

    // function index to function number.
    // PFs map straight through, VFs start at VF_OFFSET.
    function automatic func_num_t func_number(input logic [IDX_W-1:0] idx);
        if (int'(idx) < PF_COUNT) begin
            return func_num_t'(idx);
        end
        return func_num_t'(VF_OFFSET + int'(idx) - PF_COUNT);
    endfunction

    assign func_last = (int'(func_idx) == F_COUNT - 1);

    // ======================================================================
    // poll FSM
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_WAIT;
            delay_cnt    <= DLY_W'(POLL_DELAY);
            func_idx     <= '0;
            cfg_addr     <= '0;
            cfg_func     <= '0;
            cfg_read     <= 1'b0;
            ext_tag_en   <= '0;
            max_read_req <= '0;
            max_payload  <= '0;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (delay_cnt != '0) begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end else begin
                        // address and function settle with the read strobe.
                        cfg_addr <= DEV_CTRL_ADDR;
                        cfg_func <= func_number(func_idx);
                        cfg_read <= 1'b1;
                        state    <= ST_READ;
                    end
                end

                ST_READ: begin
                    if (cfg_done) begin
                        cfg_read <= 1'b0;

                        // only this function's slots change.
                        ext_tag_en[func_idx]   <= cfg_rdata[DEV_CTRL_EXT_TAG];
                        max_read_req[func_idx] <= cfg_rdata[DEV_CTRL_MRRS_LSB +: SZ_W];
                        max_payload[func_idx]  <= cfg_rdata[DEV_CTRL_MPS_LSB +: SZ_W];

                        if (func_last) begin
                            func_idx <= '0;
                        end else begin
                            func_idx <= func_idx + 1'b1;
                        end

                        delay_cnt <= DLY_W'(POLL_DELAY);
                        state     <= ST_WAIT;
                    end
                end

                default: begin
                    state    <= ST_WAIT;
                    cfg_read <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: source/pcie_cfg_pkg.sv
// PCIe configuration shim shared definitions.
// width types, read request structs and Device Control field positions.

package pcie_cfg_pkg;

    // ======================================================================
    // width types
    // ======================================================================

    // configuration management function number.
    typedef logic [7:0] func_num_t;

    // dword address into configuration space.
    typedef logic [9:0] cfg_addr_t;

    // PCIe size code, 128 bytes shifted left by the code.
    typedef logic [2:0] size_code_t;

    typedef logic [7:0] tag_t;

    // byte length, up to 4096.
    typedef logic [12:0] byte_len_t;

    typedef logic [63:0] dma_addr_t;

    // ======================================================================
    // Device Control register
    // ======================================================================

    // byte offset of Device Control within the PCIe capability.
    localparam int DEV_CTRL_OFFSET = 8;

    // field positions.
    localparam int DEV_CTRL_EXT_TAG  = 8;
    localparam int DEV_CTRL_MPS_LSB  = 5;
    localparam int DEV_CTRL_MRRS_LSB = 12;

    // last tag before wrap when extended tags are off.
    localparam int TAG_LAST_BASIC = 31;

    // ======================================================================
    // read request structs
    // ======================================================================

    // DMA read request, splitter input.
    typedef struct packed {
        func_num_t func;
        dma_addr_t addr;
        byte_len_t len;
    } rd_req_t;

    // read request TLP, splitter output.
    typedef struct packed {
        func_num_t func;
        dma_addr_t addr;
        byte_len_t len;
        tag_t      tag;
    } rd_tlp_t;

    // byte limit of a size code.
    // reserved codes above 4096 bytes saturate, no request is that long.
    function automatic byte_len_t size_bytes(input size_code_t code);
        if (code > 3'd5) begin
            return byte_len_t'(4096);
        end
        return byte_len_t'(13'd128 << code);
    endfunction

endpackage
